/* verif/chan_est_trace.txt */
# T test | C addr data_hex | B stall_cycles
# D bits_hex, then 16 actual codes and 16 expected errors, lane 0 first
T 1
D a5c3 -128 127 0 1 -1 50 -50 9 -9 64 -64 33 -33 12 5 -5
  128 -127 0 -1 1 -50 50 -9 9 -64 64 -33 33 -12 -5 5
D 0001 1 2 3 4 5 6 7 8 9 10 11 12 13 14 15 16 -1 -2 -3 -4 -5 -6 -7 -8 -9 -10 -11 -12 -13 -14 -15 -16
T 2
C 0 006
C 1 007
C 2 008
C 3 009
C 4 00a
C 5 00d
C 6 010
C 7 013
C 8 01a
C 9 024
C 10 035
C 11 056
C 12 0a0
C 13 12e
C 14 04f
C 15 000
C 16 0003
D ffff 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 -103 -101 -99 -97 -94 -91 -87 -82 -76 -67 -53 -32 8 84 103 103
D ffff 3 3 3 3 3 3 3 3 3 3 3 3 3 3 3 3 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100
D 0000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 102 100 98 96 93 90 86 81 75 66 53 31 -9 -84 -104 -104
D 0000 -4 -4 -4 -4 -4 -4 -4 -4 -4 -4 -4 -4 -4 -4 -4 -4
  -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100
D ffff 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 -103 -101 -99 -97 -94 -91 -87 -82 -76 -67 -53 -32 8 84 103 103
T 4
C 16 0006
D 0000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 127 127 127 127 127 127 127 127 127 127 106 63 -17 -128 -128 -128
C 16 fffd
D ffff 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
  -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -126 34 127 127 127
T 3
C 0 1ff
C 1 1ff
C 2 1ff
C 3 1ff
C 4 1ff
C 5 1ff
C 6 1ff
C 7 1ff
C 8 1ff
C 9 1ff
C 10 1ff
C 11 1ff
C 12 1ff
C 13 1ff
C 14 1ff
C 15 1ff
C 16 0000
D ffff 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127
D 0000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 127 127 127 127 127 127 127 0 -128 -128 -128 -128 -128 -128 -128 -128
D 0000 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100
  -228 -228 -228 -228 -228 -228 -228 -228 -228 -228 -228 -228 -228 -228 -228 -228
T 5
D 0000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
  -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128
D 0000 -28 -28 -28 -28 -28 -28 -28 -28 -28 -28 -28 -28 -28 -28 -28 -28
  -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100
B 6
D ffff 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 -128 -128 -128 -128 -128 -128 -128 0 127 127 127 127 127 127 127 127
D ffff 27 27 27 27 27 27 27 27 27 27 27 27 27 27 27 27 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100
B 4
D 0000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 127 127 127 127 127 127 127 0 -128 -128 -128 -128 -128 -128 -128 -128
D 0000 28 28 28 28 28 28 28 28 28 28 28 28 28 28 28 28
  -156 -156 -156 -156 -156 -156 -156 -156 -156 -156 -156 -156 -156 -156 -156 -156
T 6
D 0000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
  -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128
D 0000 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100 -100
  -28 -28 -28 -28 -28 -28 -28 -28 -28 -28 -28 -28 -28 -28 -28 -28
D ffff 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 -128 -128 -128 -128 -128 -128 -128 0 127 127 127 127 127 127 127 127
D ffff 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 77 77 77 77 77 77 77 77 77 77 77 77 77 77 77 77

/* tb.f */
+incdir+source
source/chan_est_types_pkg.sv
source/chan_cfg_pkg.sv
source/bit_history.sv
source/chan_cfg_regs.sv
source/channel_filter.sv
source/error_collector.sv
source/chan_est_top.sv
verif/tb.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, and search the log for the fail message.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb -f tb.f -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "build or run error, see build.log and sim.log"; exit 1; }
cat sim.log
if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0

/* verif/tb.sv */
`timescale 1ns/1ps
`include "chan_est_consts.svh"

module tb;

    import chan_est_types_pkg::*;
    import chan_cfg_pkg::*;

    localparam int WAIT_LIMIT = 200;
    localparam int WORD_W = `CHAN_LANES * `CHAN_ERR_W;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    logic                   in_ready;
    logic [`CHAN_LANES-1:0] in_bits;
    code_t                  in_codes [0:`CHAN_LANES-1];
    logic                   cfg_valid;
    cfg_addr_t              cfg_addr;
    cfg_word_u              cfg_data;
    logic                   out_valid;
    logic                   out_ready;
    err_t                   out_err [0:`CHAN_LANES-1];

    // expected error words, lane 0 in the low bits.
    logic [WORD_W-1:0] exp_q [$];

    int err_cnt = 0;
    int test_errs = 0;
    int words_done = 0;
    int total_words = 0;
    int tests_done = 0;
    int cur_test = 0;
    int cyc = 0;
    int hold_cnt = 0;
    bit rand_ready = 0;
    bit lat_test = 0;
    bit timed_out = 0;
    int first_acc_cyc = -1;
    int first_out_cyc = -1;
    int last_out_cyc = -1;

    chan_est_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_bits   (in_bits),
        .in_codes  (in_codes),
        .cfg_valid (cfg_valid),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_err   (out_err)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc++;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_val(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("Mismatch at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // a record that ends early would leave stale fields behind.
    task automatic record_complete(input int got, input int want);
        if (got != want) begin
            $display("Error: a record in the trace file is incomplete");
            err_cnt++;
        end
    endtask

    // returns with the time at 2 ns after a rising edge.
    task automatic drain(output bit ok);
        int waited;
        waited = 0;
        ok = 1'b1;
        while (exp_q.size() != 0) begin
            if (waited == WAIT_LIMIT) begin
                $display("Error: timeout, expected words never came out of the DUT");
                ok = 1'b0;
                break;
            end
            waited++;
            @(posedge clk);
            #2;
        end
    endtask

    task automatic send_word(input logic [WORD_W-1:0] exp_word, output bit ok);
        int waited;
        waited = 0;
        ok = 1'b1;
        in_valid = 1'b1;
        exp_q.push_back(exp_word);
        @(negedge clk);
        while (!in_ready) begin
            if (waited == WAIT_LIMIT) begin
                $display("Error: timeout, the DUT never accepted an input word");
                ok = 1'b0;
                break;
            end
            waited++;
            @(negedge clk);
        end
        if (ok && lat_test && first_acc_cyc < 0) begin
            first_acc_cyc = cyc;
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    // writes go in only with the pipeline empty.
    task automatic write_cfg(input int addr, input logic [15:0] val, output bit ok);
        drain(ok);
        cfg_valid = 1'b1;
        cfg_addr = cfg_addr_t'(addr);
        cfg_data = val;
        @(posedge clk);
        #2;
        cfg_valid = 1'b0;
    endtask

    task automatic finish_test(output bit ok);
        drain(ok);
        if (lat_test) begin
            check_val("first output latency in cycles", first_out_cyc - first_acc_cyc, 3);
        end
        $display("test %0d done: %0d words checked, %0d errors",
                 cur_test, words_done, err_cnt - test_errs);
        tests_done++;
        total_words += words_done;
        rand_ready = 1'b0;
        lat_test = 1'b0;
    endtask

    task automatic start_test(input int n);
        cur_test = n;
        words_done = 0;
        test_errs = err_cnt;
        rand_ready = (n == 5);
        lat_test = (n == 6);
        first_acc_cyc = -1;
        first_out_cyc = -1;
        last_out_cyc = -1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output side.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        #3;
        if (hold_cnt > 0) begin
            out_ready = 1'b0;
            hold_cnt--;
        end else if (rand_ready) begin
            out_ready = 1'($urandom % 2);
        end else begin
            out_ready = 1'b1;
        end
    end

    // a transfer seen here completes on the next rising edge.
    always @(negedge clk) begin
        logic [WORD_W-1:0] w;
        err_t e;
        if (rst_n && out_valid && lat_test && first_out_cyc < 0) begin
            first_out_cyc = cyc;
        end
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0d ns: output word arrived with nothing expected", $time);
                err_cnt++;
            end else begin
                w = exp_q.pop_front();
                for (int i = 0; i < `CHAN_LANES; i++) begin
                    e = w[i*`CHAN_ERR_W +: `CHAN_ERR_W];
                    check_val($sformatf("lane %0d", i), int'(out_err[i]), int'(e));
                end
                words_done++;
            end
            if (lat_test) begin
                if (last_out_cyc >= 0) begin
                    check_val("gap between output words", cyc - last_out_cyc, 1);
                end
                last_out_cyc = cyc;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // trace player.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int fd;
        int r;
        int fields;
        int ch;
        int n;
        int addr;
        int v;
        logic [15:0] val;
        logic [WORD_W-1:0] w;
        string line;
        bit ok;
        void'($urandom(32'hab830ddf));
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_bits = '0;
        for (int i = 0; i < `CHAN_LANES; i++) begin
            in_codes[i] = '0;
        end
        cfg_valid = 1'b0;
        cfg_addr = '0;
        cfg_data = '0;
        out_ready = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_val("out_valid after reset", int'(out_valid), 0);
        check_val("in_ready after reset", int'(in_ready), 1);
        fd = $fopen("verif/chan_est_trace.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open verif/chan_est_trace.txt");
            err_cnt++;
        end else begin
            ok = 1'b1;
            while (ok && $fscanf(fd, " %c", ch) == 1) begin
                case (ch)
                    "#": void'($fgets(line, fd));
                    "T": begin
                        r = $fscanf(fd, " %d", n);
                        record_complete(r, 1);
                        if (cur_test > 0) begin
                            finish_test(ok);
                        end
                        start_test(n);
                    end
                    "C": begin
                        r = $fscanf(fd, " %d %h", addr, val);
                        record_complete(r, 2);
                        write_cfg(addr, val, ok);
                    end
                    "B": begin
                        r = $fscanf(fd, " %d", n);
                        record_complete(r, 1);
                        hold_cnt = n;
                    end
                    "D": begin
                        r = $fscanf(fd, " %h", val);
                        fields = r;
                        in_bits = val;
                        for (int i = 0; i < `CHAN_LANES; i++) begin
                            r = $fscanf(fd, " %d", v);
                            fields += r;
                            in_codes[i] = code_t'(v);
                        end
                        for (int i = 0; i < `CHAN_LANES; i++) begin
                            r = $fscanf(fd, " %d", v);
                            fields += r;
                            w[i*`CHAN_ERR_W +: `CHAN_ERR_W] = err_t'(v);
                        end
                        record_complete(fields, 2 * `CHAN_LANES + 1);
                        send_word(w, ok);
                    end
                    default: begin
                        $display("Error: unknown record in the trace file");
                        err_cnt++;
                    end
                endcase
            end
            $fclose(fd);
            if (ok && cur_test > 0) begin
                finish_test(ok);
            end
            timed_out = !ok;
        end
        $display("tests: %0d, words checked: %0d, errors: %0d", tests_done, total_words, err_cnt);
        if (err_cnt == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* source/chan_est_top.sv */
`timescale 1ns/1ps
`include "chan_est_consts.svh"

module chan_est_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [`CHAN_LANES-1:0]    in_bits,
    input  chan_est_types_pkg::code_t in_codes [0:`CHAN_LANES-1],
    input  logic                      cfg_valid,
    input  chan_cfg_pkg::cfg_addr_t   cfg_addr,
    input  chan_cfg_pkg::cfg_word_u   cfg_data,
    output logic                      out_valid,
    input  logic                      out_ready,
    output chan_est_types_pkg::err_t  out_err [0:`CHAN_LANES-1]
);

    import chan_est_types_pkg::*;

    logic                   advance;
    logic                   win_valid;
    logic [`CHAN_WIN_W-1:0] window;
    code_t                  win_codes [0:`CHAN_LANES-1];
    coef_t                  taps [0:`CHAN_TAPS-1];
    shift_t                 shift;
    logic [`CHAN_LANES-1:0] lane_valid;
    code_t                  est_codes [0:`CHAN_LANES-1];
    code_t                  act_codes [0:`CHAN_LANES-1];

    assign in_ready = advance;

    bit_history hist_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance   (advance),
        .in_valid  (in_valid),
        .in_bits   (in_bits),
        .in_codes  (in_codes),
        .win_valid (win_valid),
        .window    (window),
        .win_codes (win_codes)
    );

    chan_cfg_regs cfg_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_valid (cfg_valid),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .taps      (taps),
        .shift     (shift)
    );

    // lane i looks at window bits i up to i plus the tap count minus one.
    for (genvar i = 0; i < `CHAN_LANES; i++) begin : g_lane
        channel_filter filt_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .advance   (advance),
            .win_valid (win_valid),
            .slice     (window[i +: `CHAN_TAPS]),
            .taps      (taps),
            .shift     (shift),
            .act_in    (win_codes[i]),
            .est_valid (lane_valid[i]),
            .est_code  (est_codes[i]),
            .act_code  (act_codes[i])
        );
    end

    // all lanes move in lock step, lane 0 speaks for them.
    error_collector coll_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .est_valid (lane_valid[0]),
        .est_codes (est_codes),
        .act_codes (act_codes),
        .out_ready (out_ready),
        .advance   (advance),
        .out_valid (out_valid),
        .out_err   (out_err)
    );

endmodule

/* source/error_collector.sv */
`timescale 1ns/1ps
`include "chan_est_consts.svh"

module error_collector (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      est_valid,
    input  chan_est_types_pkg::code_t est_codes [0:`CHAN_LANES-1],
    input  chan_est_types_pkg::code_t act_codes [0:`CHAN_LANES-1],
    input  logic                      out_ready,
    output logic                      advance,
    output logic                      out_valid,
    output chan_est_types_pkg::err_t  out_err [0:`CHAN_LANES-1]
);

    import chan_est_types_pkg::*;

    err_t diff [0:`CHAN_LANES-1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline flow control.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // the whole pipe moves when the output slot is free or draining.
    assign advance = !out_valid || out_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // per lane error.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one extra bit covers the full span of two 8-bit codes.
    always_comb begin
        for (int i = 0; i < `CHAN_LANES; i++) begin
            diff[i] = err_t'(est_codes[i]) - err_t'(act_codes[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= est_valid;
        end
    end

    // held while the consumer stalls.
    always_ff @(posedge clk) begin
        if (advance) begin
            out_err <= diff;
        end
    end

endmodule

/* source/channel_filter.sv */
`timescale 1ns/1ps
`include "chan_est_consts.svh"

module channel_filter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       advance,
    input  logic                       win_valid,
    input  logic [`CHAN_TAPS-1:0]      slice,
    input  chan_est_types_pkg::coef_t  taps [0:`CHAN_TAPS-1],
    input  chan_est_types_pkg::shift_t shift,
    input  chan_est_types_pkg::code_t  act_in,
    output logic                       est_valid,
    output chan_est_types_pkg::code_t  est_code,
    output chan_est_types_pkg::code_t  act_code
);

    import chan_est_types_pkg::*;

    acc_t  tap_sum;
    acc_t  scaled;
    code_t est_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pulse response applied to the slice.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tap 0 sees the newest bit of the slice, the last tap sees bit 0.
    always_comb begin
        tap_sum = '0;
        for (int k = 0; k < `CHAN_TAPS; k++) begin
            if (slice[`CHAN_TAPS-1-k]) begin
                tap_sum = tap_sum + acc_t'(taps[k]);
            end else begin
                tap_sum = tap_sum - acc_t'(taps[k]);
            end
        end
    end

    // arithmetic shift keeps the sign.
    assign scaled = tap_sum >>> shift;

    always_comb begin
        if (scaled > CODE_MAX) begin
            est_next = code_t'(CODE_MAX);
        end else if (scaled < CODE_MIN) begin
            est_next = code_t'(CODE_MIN);
        end else begin
            est_next = code_t'(scaled);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage register.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            est_valid <= 1'b0;
        end else if (advance) begin
            est_valid <= win_valid;
        end
    end

    // actual code rides along so it meets its estimate downstream.
    always_ff @(posedge clk) begin
        if (advance) begin
            est_code <= est_next;
            act_code <= act_in;
        end
    end

endmodule

/* source/chan_cfg_regs.sv */
`timescale 1ns/1ps
`include "chan_est_consts.svh"

module chan_cfg_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cfg_valid,
    input  chan_cfg_pkg::cfg_addr_t    cfg_addr,
    input  chan_cfg_pkg::cfg_word_u    cfg_data,
    output chan_est_types_pkg::coef_t  taps [0:`CHAN_TAPS-1],
    output chan_est_types_pkg::shift_t shift
);

    import chan_cfg_pkg::*;

    localparam int TAP_IDX_W = $clog2(`CHAN_TAPS);

    logic                 tap_we;
    logic                 shift_we;
    logic [TAP_IDX_W-1:0] tap_idx;

    // address decode.
    assign tap_we = cfg_valid && (cfg_addr <= CFG_TAP_LAST);
    assign shift_we = cfg_valid && (cfg_addr == CFG_SHIFT_ADDR);
    assign tap_idx = cfg_addr[TAP_IDX_W-1:0];

    // addresses above the shift register are silently dropped.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < `CHAN_TAPS; k++) begin
                taps[k] <= '0;
            end
            shift <= '0;
        end else begin
            if (tap_we) begin
                taps[tap_idx] <= cfg_data.coef_view.coef;
            end
            if (shift_we) begin
                shift <= cfg_data.shift_view.shift;
            end
        end
    end

endmodule

/* source/bit_history.sv */
`timescale 1ns/1ps
`include "chan_est_consts.svh"

module bit_history (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      advance,
    input  logic                      in_valid,
    input  logic [`CHAN_LANES-1:0]    in_bits,
    input  chan_est_types_pkg::code_t in_codes [0:`CHAN_LANES-1],
    output logic                      win_valid,
    output logic [`CHAN_WIN_W-1:0]    window,
    output chan_est_types_pkg::code_t win_codes [0:`CHAN_LANES-1]
);

    // newest bits of the last accepted word, oldest at bit 0.
    logic [`CHAN_HIST_W-1:0] hist;
    logic                    accept;

    assign accept = advance && in_valid;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control state.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
            hist <= '0;
        end else begin
            if (advance) begin
                win_valid <= in_valid;
            end
            // bubbles must not push the history along.
            if (accept) begin
                hist <= in_bits[`CHAN_LANES-1 -: `CHAN_HIST_W];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // window and codes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // current word lands on top, history fills bits 0 up.
    always_ff @(posedge clk) begin
        if (advance) begin
            window <= {in_bits, hist};
            win_codes <= in_codes;
        end
    end

endmodule

/* source/chan_cfg_pkg.sv */
`include "chan_est_consts.svh"

package chan_cfg_pkg;

    import chan_est_types_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register map.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [`CHAN_CFG_ADDR_W-1:0] cfg_addr_t;

    // taps sit at addresses 0 up to this one, tap index equals address.
    localparam cfg_addr_t CFG_TAP_LAST = cfg_addr_t'(`CHAN_TAPS - 1);
    localparam cfg_addr_t CFG_SHIFT_ADDR = cfg_addr_t'(`CHAN_TAPS);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data word views, the address picks which one is meant.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [`CHAN_CFG_DATA_W-`CHAN_COEF_W-1:0] rsvd;
        coef_t coef;
    } cfg_coef_view_t;

    typedef struct packed {
        logic [`CHAN_CFG_DATA_W-`CHAN_SHIFT_W-1:0] rsvd;
        shift_t shift;
    } cfg_shift_view_t;

    typedef union packed {
        cfg_coef_view_t coef_view;
        cfg_shift_view_t shift_view;
    } cfg_word_u;

endpackage

/* source/chan_est_types_pkg.sv */
`include "chan_est_consts.svh"

package chan_est_types_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath value types.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one sample of the estimated pulse response.
    typedef logic signed [`CHAN_COEF_W-1:0] coef_t;

    // adc code as received, or as predicted by a lane.
    typedef logic signed [`CHAN_CODE_W-1:0] code_t;

    // signed sum over all taps of one lane.
    typedef logic signed [`CHAN_ACC_W-1:0] acc_t;

    // estimate minus actual, never overflows.
    typedef logic signed [`CHAN_ERR_W-1:0] err_t;

    // arithmetic right shift applied to the tap sum.
    typedef logic [`CHAN_SHIFT_W-1:0] shift_t;

    // code range expressed at sum width, used for saturation.
    localparam acc_t CODE_MAX = acc_t'((1 << (`CHAN_CODE_W - 1)) - 1);
    localparam acc_t CODE_MIN = acc_t'(-(1 << (`CHAN_CODE_W - 1)));

endpackage

/* source/chan_est_consts.svh */
`ifndef CHAN_EST_CONSTS_SVH
`define CHAN_EST_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lane and tap geometry.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CHAN_LANES 16
`define CHAN_TAPS 16

// one word plus the bits carried over from the word before.
`define CHAN_HIST_W (`CHAN_TAPS - 1)
`define CHAN_WIN_W (`CHAN_LANES + `CHAN_TAPS - 1)

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath widths.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CHAN_COEF_W 10
`define CHAN_CODE_W 8
`define CHAN_ERR_W 9
`define CHAN_SHIFT_W 2
// 16 taps of full scale need 4 bits on top of the coefficient, plus sign.
`define CHAN_ACC_W 15
`define CHAN_CFG_DATA_W 16
`define CHAN_CFG_ADDR_W 5

`endif
